//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

verilator --binary --timing --assert -f src.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- src.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/fetch_entry_reg.sv
verilog/inst_decoder.sv
verilog/decode_out_reg.sv
verilog/decode_stage.sv
verif/decode_props.sv
verif/decode_tb.sv

//--- verif/decode_props.sv
`timescale 1ns/1ps

module decode_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_valid,
    input logic                    out_valid,
    input decode_pkg::decode_out_t out_bus
);

    // no result leaves the stage right after reset
    a_rst_clear: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after reset");

    // fixed two cycle latency
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    a_no_ex_code: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_bus.ex) |-> (out_bus.excode == '0))
        else $error("excode set without an exception");

endmodule

bind decode_stage decode_props u_decode_props (.*);

//--- verif/decode_tb.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_tb;

    import decode_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    fetch_entry_t in_entry;
    logic         has_int;
    logic         out_valid;
    decode_out_t  out_bus;

    decode_out_t  exp_q[$];
    int           stamp_q[$];
    int           cyc;
    int           checks;
    int           errors;
    logic [31:0]  lfsr;

    decode_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // galois lfsr stepped once per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // expected result from the decode and exception rules
    function automatic decode_out_t model(input fetch_entry_t e, input logic intr);
        decode_out_t  o;
        decode_ctrl_t c;
        logic [5:0]   op;
        logic [5:0]   fn;
        logic [4:0]   rs, rt, rd, sa;
        logic         undef, sys, brk, imm_op;
        op = e.inst[31:26];
        fn = e.inst[5:0];
        rs = e.inst[25:21];
        rt = e.inst[20:16];
        rd = e.inst[15:11];
        sa = e.inst[10:6];
        c = '0;
        c.alu_op = ALU_ADD;
        c.br_kind = BR_NONE;
        c.rs1 = rs;
        c.rs2 = rt;
        c.dest = rd;
        c.imm = e.inst[15:0];
        undef = 1'b0;
        sys = 1'b0;
        brk = 1'b0;
        imm_op = 1'b0;
        if (op == 6'h00) begin
            case (fn)
                6'h00, 6'h02, 6'h03: begin
                    undef = (rs != 0);
                    c.alu_op = (fn == 6'h00) ? ALU_SLL : (fn == 6'h02) ? ALU_SRL : ALU_SRA;
                    c.src1_is_sa = !undef;
                end
                6'h21: c.alu_op = ALU_ADD;
                6'h23: c.alu_op = ALU_SUB;
                6'h24: c.alu_op = ALU_AND;
                6'h25: c.alu_op = ALU_OR;
                6'h26: c.alu_op = ALU_XOR;
                6'h27: c.alu_op = ALU_NOR;
                6'h2a: c.alu_op = ALU_SLT;
                6'h2b: c.alu_op = ALU_SLTU;
                6'h08: undef = (rt != 0) || (rd != 0) || (sa != 0);
                6'h0c: sys = 1'b1;
                6'h0d: brk = 1'b1;
                default: undef = 1'b1;
            endcase
            if (fn[5] && sa != 0) undef = 1'b1;
            if (undef) c.alu_op = ALU_ADD;
            c.gr_we = !undef && fn != 6'h08 && !sys && !brk;
            if (fn == 6'h08 && !undef) c.br_kind = BR_JR;
        end else begin
            case (op)
                6'h09, 6'h0a, 6'h0b, 6'h23: begin
                    imm_op = 1'b1;
                    c.src2_is_imm = 1'b1;
                end
                6'h0c, 6'h0d, 6'h0e: begin
                    imm_op = 1'b1;
                    c.src2_is_zimm = 1'b1;
                end
                6'h0f: begin
                    undef = (rs != 0);
                    imm_op = !undef;
                    c.src2_is_imm = !undef;
                end
                6'h2b: begin
                    c.src2_is_imm = 1'b1;
                    c.mem_we = 1'b1;
                end
                6'h04: c.br_kind = BR_BEQ;
                6'h05: c.br_kind = BR_BNE;
                6'h02: c.br_kind = BR_J;
                6'h03: begin
                    c.br_kind = BR_JAL;
                    c.dest = 5'd31;
                    c.gr_we = 1'b1;
                    c.src1_is_pc = 1'b1;
                    c.src2_is_8 = 1'b1;
                end
                default: undef = 1'b1;
            endcase
            // alu operation of the immediate forms
            case (op)
                6'h0a: c.alu_op = ALU_SLT;
                6'h0b: c.alu_op = ALU_SLTU;
                6'h0c: c.alu_op = ALU_AND;
                6'h0d: c.alu_op = ALU_OR;
                6'h0e: c.alu_op = ALU_XOR;
                6'h0f: c.alu_op = undef ? ALU_ADD : ALU_LUI;
                default: c.alu_op = ALU_ADD;
            endcase
            c.res_from_mem = (op == 6'h23);
            if (imm_op) begin
                c.dest = rt;
                c.rs2 = '0;
                c.gr_we = 1'b1;
            end
        end
        o.pc = e.pc;
        o.ctrl = c;
        o.ex = e.fetch_ex | intr | undef | sys | brk;
        o.excode = intr ? `EXC_INT : e.fetch_ex ? e.fetch_excode : undef ? `EXC_RI :
                   sys ? `EXC_SYS : brk ? `EXC_BP : 5'd0;
        return o;
    endfunction

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // compare each result with the oldest expected entry
    always @(negedge clk) begin
        decode_out_t e;
        int          s;
        if (rst_n !== 1'b1) begin
            if (cyc > 0 && out_valid !== 1'b0) begin
                errors++;
                $display("out_valid is not low during reset at t=%0t", $time);
            end
        end else if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("out_valid is high with no entry pending at t=%0t", $time);
            end else begin
                e = exp_q.pop_front();
                s = stamp_q.pop_front();
                compare("latency", 128'(cyc - s), 128'd2);
                compare("out_bus.pc", 128'(out_bus.pc), 128'(e.pc));
                compare("out_bus.ctrl", 128'(out_bus.ctrl), 128'(e.ctrl));
                compare("out_bus.ex", 128'(out_bus.ex), 128'(e.ex));
                compare("out_bus.excode", 128'(out_bus.excode), 128'(e.excode));
            end
        end else if (out_valid !== 1'b0) begin
            errors++;
            $display("out_valid is unknown after reset at t=%0t", $time);
        end
    end

    task automatic send(input logic [31:0] inst, input logic fex, input logic [4:0] fcode,
                        input logic intr);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_entry.pc = 32'({rand_bits(14), 2'b00}) + 32'hbfc0_0000;
        in_entry.inst = inst;
        in_entry.fetch_ex = fex;
        in_entry.fetch_excode = fcode;
        has_int = intr;
        exp_q.push_back(model(in_entry, intr));
        stamp_q.push_back(cyc);
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        has_int = 1'b0;
    endtask

    task automatic drain();
        int n;
        idle();
        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout, results still missing from the DUT");
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic reg_alu_ops();
        logic [5:0] fns[11] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27,
                                6'h00, 6'h02, 6'h03};
        logic [4:0] rs, rt, rd, sa;
        foreach (fns[i]) begin
            rs = 5'(rand_bits(5));
            rt = 5'(rand_bits(5));
            rd = 5'(rand_bits(5));
            sa = 5'(rand_bits(5));
            if (i < 8) send({6'h00, rs, rt, rd, 5'd0, fns[i]}, 1'b0, 5'd0, 1'b0);
            else send({6'h00, 5'd0, rt, rd, sa, fns[i]}, 1'b0, 5'd0, 1'b0);
        end
        drain();
    endtask

    task automatic imm_mem_ops();
        logic [5:0] ops[9] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b};
        logic [4:0] rs;
        foreach (ops[i]) begin
            rs = (ops[i] == 6'h0f) ? 5'd0 : 5'(rand_bits(5));
            send({ops[i], rs, 5'(rand_bits(5)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        end
        drain();
    endtask

    task automatic branch_jump_ops();
        send({6'h04, 5'(rand_bits(5)), 5'(rand_bits(5)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        send({6'h05, 5'(rand_bits(5)), 5'(rand_bits(5)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        send({6'h02, 10'(rand_bits(10)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        send({6'h03, 10'(rand_bits(10)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        send({6'h00, 5'(rand_bits(5)), 15'd0, 6'h08}, 1'b0, 5'd0, 1'b0);
        drain();
    endtask

    task automatic exception_codes();
        send(32'hfc00_0000, 1'b0, 5'd0, 1'b0);
        send({6'h00, 5'd3, 15'd0, 6'h00}, 1'b0, 5'd0, 1'b0);
        send(32'h0000_000c, 1'b0, 5'd0, 1'b0);
        send(32'h0000_000d, 1'b0, 5'd0, 1'b0);
        send(32'hfc00_0000, 1'b1, 5'd4, 1'b0);
        send(32'h0000_000c, 1'b1, 5'd5, 1'b1);
        send(32'h2402_0001, 1'b0, 5'd0, 1'b1);
        drain();
    endtask

    // back to back entries and then a gap
    task automatic pipeline_order();
        for (int i = 0; i < 4; i++) begin
            send({6'h09, 5'(rand_bits(5)), 5'(rand_bits(5)), rand_bits(16)}, 1'b0, 5'd0, 1'b0);
        end
        idle();
        idle();
        send({6'h00, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)), 5'd0, 6'h25},
             1'b0, 5'd0, 1'b0);
        drain();
    endtask

    initial begin
        lfsr = 32'hc47e_0bdc;
        cyc = 0;
        checks = 0;
        errors = 0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_entry = '0;
        has_int = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reg_alu_ops();
        imm_mem_ops();
        branch_jump_ops();
        exception_codes();
        pipeline_order();
        repeat (3) @(posedge clk);
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verilog/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// datapath widths
`define INST_W      32
`define REG_ADDR_W  5
`define IMM_W       16

// exception codes, cause register encoding
`define EXC_CODE_W  5
`define EXC_INT     5'd0
`define EXC_SYS     5'd8
`define EXC_BP      5'd9
`define EXC_RI      5'd10

`endif

//--- verilog/decode_out_reg.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_out_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     entry_valid,
    input  decode_pkg::fetch_entry_t entry,
    input  logic                     entry_int,
    input  decode_pkg::decode_ctrl_t ctrl,
    input  logic                     inst_undef,
    input  logic                     inst_syscall,
    input  logic                     inst_break,
    output logic                     out_valid,
    output decode_pkg::decode_out_t  out_bus
);

    import decode_pkg::*;

    decode_out_t            next_bus;
    logic                   ex;
    logic [`EXC_CODE_W-1:0] excode;

    // decode-time causes only count on a live entry
    assign ex = entry.fetch_ex
              | ((entry_int | inst_undef | inst_syscall | inst_break) & entry_valid);

    // interrupt wins, then the older fetch fault
    assign excode = entry_int      ? `EXC_INT           :
                    entry.fetch_ex ? entry.fetch_excode :
                    inst_undef     ? `EXC_RI            :
                    inst_syscall   ? `EXC_SYS           :
                    inst_break     ? `EXC_BP            :
                                     '0;

    assign next_bus.pc     = entry.pc;
    assign next_bus.ctrl   = ctrl;
    assign next_bus.ex     = ex;
    assign next_bus.excode = excode;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= entry_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (entry_valid) begin
            out_bus <= next_bus;
        end
    end

endmodule

//--- verilog/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    // major opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_BREAK   = 6'h0d,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR
    } br_kind_e;

    typedef struct packed {
        logic [`INST_W-1:0]     pc;
        logic [`INST_W-1:0]     inst;
        logic                   fetch_ex;
        logic [`EXC_CODE_W-1:0] fetch_excode;
    } fetch_entry_t;

    typedef struct packed {
        alu_op_e                alu_op;
        br_kind_e               br_kind;
        logic                   src1_is_sa;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_zimm;
        logic                   src2_is_8;
        logic                   res_from_mem;
        logic                   gr_we;
        logic                   mem_we;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`IMM_W-1:0]      imm;
    } decode_ctrl_t;

    typedef struct packed {
        logic [`INST_W-1:0]     pc;
        decode_ctrl_t           ctrl;
        logic                   ex;
        logic [`EXC_CODE_W-1:0] excode;
    } decode_out_t;

endpackage

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  decode_pkg::fetch_entry_t in_entry,
    input  logic                     has_int,
    output logic                     out_valid,
    output decode_pkg::decode_out_t  out_bus
);

    import decode_pkg::*;

    logic         entry_valid;
    fetch_entry_t entry;
    logic         entry_int;
    decode_ctrl_t ctrl;
    logic         inst_undef;
    logic         inst_syscall;
    logic         inst_break;

    // stage 1 capture
    fetch_entry_reg u_fetch_entry_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_entry    (in_entry),
        .has_int     (has_int),
        .entry_valid (entry_valid),
        .entry       (entry),
        .entry_int   (entry_int)
    );

    inst_decoder u_inst_decoder (
        .entry        (entry),
        .ctrl         (ctrl),
        .inst_undef   (inst_undef),
        .inst_syscall (inst_syscall),
        .inst_break   (inst_break)
    );

    // stage 2 exception resolve and register
    decode_out_reg u_decode_out_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .entry_valid  (entry_valid),
        .entry        (entry),
        .entry_int    (entry_int),
        .ctrl         (ctrl),
        .inst_undef   (inst_undef),
        .inst_syscall (inst_syscall),
        .inst_break   (inst_break),
        .out_valid    (out_valid),
        .out_bus      (out_bus)
    );

endmodule

//--- verilog/fetch_entry_reg.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module fetch_entry_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  decode_pkg::fetch_entry_t in_entry,
    input  logic                     has_int,
    output logic                     entry_valid,
    output decode_pkg::fetch_entry_t entry,
    output logic                     entry_int
);

    // valid strobe, one per fetched entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= in_valid;
        end
    end

    // payload only moves on a valid entry
    // interrupt level is sampled together with the entry
    always_ff @(posedge clk) begin
        if (in_valid) begin
            entry     <= in_entry;
            entry_int <= has_int;
        end
    end

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module inst_decoder (
    input  decode_pkg::fetch_entry_t entry,
    output decode_pkg::decode_ctrl_t ctrl,
    output logic                     inst_undef,
    output logic                     inst_syscall,
    output logic                     inst_break
);

    import decode_pkg::*;

    opcode_e                op;
    funct_e                 func;
    logic [`REG_ADDR_W-1:0] rs, rt, rd, sa;
    logic                   special, rs_zero, sa_zero;

    logic inst_addu, inst_subu, inst_slt, inst_sltu, inst_and, inst_or;
    logic inst_xor, inst_nor, inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori;
    logic inst_lui, inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic alu_reg, alu_imm, dst_is_rt;

    // instruction fields
    assign op      = opcode_e'(entry.inst[31:26]);
    assign rs      = entry.inst[25:21];
    assign rt      = entry.inst[20:16];
    assign rd      = entry.inst[15:11];
    assign sa      = entry.inst[10:6];
    assign func    = funct_e'(entry.inst[5:0]);
    assign special = (op == OP_SPECIAL);
    assign rs_zero = (rs == '0);
    assign sa_zero = (sa == '0);

    // R-type, unused fields must be zero
    assign inst_addu  = special && func == FN_ADDU && sa_zero;
    assign inst_subu  = special && func == FN_SUBU && sa_zero;
    assign inst_slt   = special && func == FN_SLT  && sa_zero;
    assign inst_sltu  = special && func == FN_SLTU && sa_zero;
    assign inst_and   = special && func == FN_AND  && sa_zero;
    assign inst_or    = special && func == FN_OR   && sa_zero;
    assign inst_xor   = special && func == FN_XOR  && sa_zero;
    assign inst_nor   = special && func == FN_NOR  && sa_zero;
    assign inst_sll   = special && func == FN_SLL  && rs_zero;
    assign inst_srl   = special && func == FN_SRL  && rs_zero;
    assign inst_sra   = special && func == FN_SRA  && rs_zero;
    assign inst_jr    = special && func == FN_JR && rt == '0 && rd == '0 && sa_zero;
    // code field of syscall and break is ignored
    assign inst_syscall = special && func == FN_SYSCALL;
    assign inst_break   = special && func == FN_BREAK;

    // I-type and J-type
    assign inst_addiu = (op == OP_ADDIU);
    assign inst_slti  = (op == OP_SLTI);
    assign inst_sltiu = (op == OP_SLTIU);
    assign inst_andi  = (op == OP_ANDI);
    assign inst_ori   = (op == OP_ORI);
    assign inst_xori  = (op == OP_XORI);
    assign inst_lui   = (op == OP_LUI) && rs_zero;
    assign inst_lw    = (op == OP_LW);
    assign inst_sw    = (op == OP_SW);
    assign inst_beq   = (op == OP_BEQ);
    assign inst_bne   = (op == OP_BNE);
    assign inst_j     = (op == OP_J);
    assign inst_jal   = (op == OP_JAL);

    assign alu_reg = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra;
    assign alu_imm = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                   | inst_xori | inst_lui;

    // anything not listed above is reserved
    assign inst_undef = !(alu_reg | alu_imm | inst_lw | inst_sw | inst_beq | inst_bne
                        | inst_j | inst_jal | inst_jr | inst_syscall | inst_break);

    // addu, addiu, lw, sw, jal and undefined all fall to add
    assign ctrl.alu_op = inst_subu                ? ALU_SUB  :
                         (inst_slt  | inst_slti)  ? ALU_SLT  :
                         (inst_sltu | inst_sltiu) ? ALU_SLTU :
                         (inst_and  | inst_andi)  ? ALU_AND  :
                         inst_nor                 ? ALU_NOR  :
                         (inst_or   | inst_ori)   ? ALU_OR   :
                         (inst_xor  | inst_xori)  ? ALU_XOR  :
                         inst_sll                 ? ALU_SLL  :
                         inst_srl                 ? ALU_SRL  :
                         inst_sra                 ? ALU_SRA  :
                         inst_lui                 ? ALU_LUI  :
                                                    ALU_ADD;

    assign ctrl.br_kind = inst_beq ? BR_BEQ :
                          inst_bne ? BR_BNE :
                          inst_j   ? BR_J   :
                          inst_jal ? BR_JAL :
                          inst_jr  ? BR_JR  :
                                     BR_NONE;

    assign ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign ctrl.src1_is_pc   = inst_jal;
    assign ctrl.src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign ctrl.src2_is_zimm = inst_andi | inst_ori | inst_xori;
    // link address is pc + 8
    assign ctrl.src2_is_8    = inst_jal;
    assign ctrl.res_from_mem = inst_lw;
    assign ctrl.gr_we        = alu_reg | alu_imm | inst_lw | inst_jal;
    assign ctrl.mem_we       = inst_sw;

    // register addresses
    assign dst_is_rt = alu_imm | inst_lw;
    assign ctrl.rs1  = rs;
    assign ctrl.rs2  = dst_is_rt ? '0 : rt;
    assign ctrl.dest = inst_jal  ? 5'd31 :
                       dst_is_rt ? rt    :
                                   rd;
    assign ctrl.imm  = entry.inst[15:0];

endmodule
